// ==== flist.f ====
+incdir+.
ex_pkg.sv
lar_rotate_mask.sv
ex_operand_forward.sv
ex_lane_align.sv
ex_result_merge.sv
ex_top.sv
tb_ex_top.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat flist.f)) tb_ex_model.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_ex_top: $(SRCS) flist.f
	verilator --binary -Wno-fatal --top-module tb_ex_top -f flist.f -o Vtb_ex_top

run: obj_dir/Vtb_ex_top
	./obj_dir/Vtb_ex_top | tee sim.log
	@if grep -q "Simulation failed" sim.log; then \
		echo "run reported a failure"; exit 1; \
	fi
	@if ! grep -q "Simulation completed successfully" sim.log; then \
		echo "run ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== tb_ex_model.svh ====
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// compilation-unit scope, include ahead of the testbench module
function automatic logic [ex_pkg::SCALAR_BITS-1:0] model_extract(ex_pkg::lar_operand_t opnd);
	int nbytes;
	int base;
	logic [ex_pkg::SCALAR_BITS-1:0] scalar;
	nbytes = 1 << opnd.int_size;
	base = opnd.data_offset & ~(nbytes - 1);
	scalar = '0;
	for (int b = 0; b < nbytes; b++)
		scalar[8*b +: 8] = opnd.data[8*(base + b) +: 8];
	return scalar;
endfunction

// source element sized by the destination, as the hardware does
function automatic logic [ex_pkg::LINE_BITS-1:0] model_insert(ex_pkg::lar_operand_t dst,
	ex_pkg::lar_operand_t src);
	int nbytes;
	int dst_base;
	int src_base;
	logic [ex_pkg::LINE_BITS-1:0] line;
	nbytes = 1 << dst.int_size;
	dst_base = dst.data_offset & ~(nbytes - 1);
	src_base = src.data_offset & ~(nbytes - 1);
	line = dst.data;
	for (int b = 0; b < nbytes; b++)
		line[8*(dst_base + b) +: 8] = src.data[8*(src_base + b) +: 8];
	return line;
endfunction

function automatic logic [ex_pkg::PC_BITS-1:0] model_branch(ex_pkg::ex_op_e op,
	logic [ex_pkg::PC_BITS-1:0] pc, logic signed [ex_pkg::PC_BITS-1:0] imm,
	logic [ex_pkg::SCALAR_BITS-1:0] scalar);
	case (op)
		ex_pkg::op_btru: return (scalar != 0) ? pc + imm : pc;
		ex_pkg::op_bfal: return (scalar == 0) ? pc + imm : pc;
		ex_pkg::op_jmp: return scalar;
		default: return pc;
	endcase
endfunction

`endif

// ==== tb_ex_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tb_ex_model.svh"

module tb_ex_top;
	import ex_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_ENTRIES = 20;
	localparam int LATENCY = 3;
	localparam int HIST_DEPTH = 3;
	localparam logic [31:0] RAND_SEED = 32'h6b93_7842;

	typedef struct
	{
		ex_instr_t instr;
		logic exp_wb_valid;
		logic [ADDR_BITS-1:0] exp_addr;
		logic [LINE_BITS-1:0] exp_data;
		logic exp_br_valid;
		logic [PC_BITS-1:0] exp_target;
	} vector_t;

	logic clk;
	logic arst_n;
	ex_instr_t instr_in;
	ex_result_t wb;
	ex_branch_t branch;

	vector_t vectors [NUM_ENTRIES];
	int num_filled;
	int errors;
	int checks;

	ex_top
	#(
		.HIST_DEPTH(HIST_DEPTH)
	)
	dut0
	(
		.clk(clk),
		.arst_n(arst_n),
		.instr_in(instr_in),
		.wb(wb),
		.branch(branch)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [LINE_BITS-1:0] random_line();
		logic [LINE_BITS-1:0] line;
		for (int w = 0; w < LINE_BITS / 32; w++)
			line[32*w +: 32] = $urandom();
		return line;
	endfunction

	function automatic lar_operand_t make_operand(logic [ADDR_BITS-1:0] addr, int off, int sz,
		bit zero_elem);
		lar_operand_t opnd;
		int nbytes;
		int base;
		nbytes = 1 << sz;
		base = off & ~(nbytes - 1);
		opnd.base_addr = addr;
		opnd.data = random_line();
		opnd.data_offset = OFFSET_BITS'(off);
		opnd.int_size = int_size_e'(sz);
		// clear the element so a branch sees a zero scalar
		if (zero_elem)
		begin
			for (int b = 0; b < nbytes; b++)
				opnd.data[8*(base + b) +: 8] = 8'h00;
		end
		return opnd;
	endfunction

	task automatic add_entry(input logic valid, input ex_op_e op, input int sz,
		input logic [ADDR_BITS-1:0] dst_addr, input int dst_off,
		input logic [ADDR_BITS-1:0] src_addr, input int src_off,
		input longint imm, input bit zero_elem);
		ex_instr_t instr;
		instr.valid = valid;
		instr.op = op;
		instr.pc = 64'h0000_0040_0000_0000 + PC_BITS'(num_filled * 4);
		instr.imm = imm;
		instr.ddest = make_operand(dst_addr, dst_off, sz, zero_elem);
		instr.dsrc0 = make_operand(src_addr, src_off, sz, 1'b0);
		vectors[num_filled].instr = instr;
		num_filled++;
	endtask

	task automatic build_vectors();
		add_entry(1, op_insert, 0, 32'h1000, 5, 32'h2000, 17, 0, 0);
		add_entry(1, op_insert, 1, 32'h3000, 6, 32'h4000, 21, 0, 0);
		add_entry(1, op_insert, 2, 32'h5000, 8, 32'h6000, 29, 0, 0);
		// forwarded from 3, 4 and 5 issues back
		add_entry(1, op_insert, 3, 32'h1000, 24, 32'h7000, 3, 0, 0);
		add_entry(1, op_insert, 1, 32'h1000, 2, 32'h8000, 30, 0, 0);
		add_entry(1, op_insert, 2, 32'h1000, 12, 32'h3000, 20, 0, 0);
		add_entry(0, op_insert, 0, 32'h0, 0, 32'h0, 0, 0, 0);
		add_entry(1, op_btru, 2, 32'hc000, 4, 32'h0, 0, -64, 0);
		// three matching entries, newest must win
		add_entry(1, op_insert, 0, 32'h1000, 31, 32'h9000, 1, 0, 0);
		add_entry(1, op_bfal, 1, 32'hb000, 14, 32'h0, 0, -8, 1);
		// same address as the branch above, nothing to forward
		add_entry(1, op_insert, 3, 32'hc000, 9, 32'hb000, 16, 0, 0);
		add_entry(1, op_btru, 0, 32'hb000, 3, 32'h0, 0, -100, 1);
		add_entry(1, op_bfal, 3, 32'hd000, 16, 32'h0, 0, -200, 0);
		add_entry(1, op_jmp, 0, 32'he000, 7, 32'h0, 0, 0, 0);
		add_entry(1, op_jmp, 1, 32'hc000, 13, 32'h0, 0, 0, 0);
		add_entry(1, op_jmp, 2, 32'hf000, 22, 32'h0, 0, 0, 0);
		add_entry(1, op_jmp, 3, 32'h1_0000, 8, 32'h0, 0, 0, 0);
		add_entry(0, op_insert, 0, 32'h0, 0, 32'h0, 0, 0, 0);
		add_entry(1, op_btru, 1, 32'h1000, 0, 32'h0, 0, -4, 0);
		add_entry(1, op_insert, 2, 32'h2000, 0, 32'h2000, 4, 0, 0);
	endtask

	task automatic compute_expected();
		ex_instr_t instr;
		int older;
		logic [SCALAR_BITS-1:0] scalar;
		for (int t = 0; t < NUM_ENTRIES; t++)
		begin
			instr = vectors[t].instr;
			// oldest visible write-back first
			for (int d = LATENCY + HIST_DEPTH - 1; d >= LATENCY; d--)
			begin
				older = t - d;
				if (older >= 0 && vectors[older].exp_wb_valid)
				begin
					if (vectors[older].exp_addr == instr.ddest.base_addr)
						instr.ddest.data = vectors[older].exp_data;
					if (vectors[older].exp_addr == instr.dsrc0.base_addr)
						instr.dsrc0.data = vectors[older].exp_data;
				end
			end
			vectors[t].exp_wb_valid = instr.valid && (instr.op == op_insert);
			vectors[t].exp_addr = instr.ddest.base_addr;
			vectors[t].exp_data = model_insert(instr.ddest, instr.dsrc0);
			vectors[t].exp_br_valid = instr.valid && (instr.op != op_insert);
			scalar = model_extract(instr.ddest);
			vectors[t].exp_target = model_branch(instr.op, instr.pc, instr.imm, scalar);
		end
	endtask

	task automatic check_value(input string what, input int idx,
		input logic [LINE_BITS-1:0] actual, input logic [LINE_BITS-1:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED at %0t ns: entry %0d %s is %h, expected %h",
				$time, idx, what, actual, expected);
		end
	endtask

	task automatic check_idle();
		check_value("wb.valid while idle", -1, LINE_BITS'(wb.valid), '0);
		check_value("branch.valid while idle", -1, LINE_BITS'(branch.valid), '0);
	endtask

	task automatic check_outputs(input int idx);
		check_value("wb.valid", idx, LINE_BITS'(wb.valid), LINE_BITS'(vectors[idx].exp_wb_valid));
		if (vectors[idx].exp_wb_valid)
		begin
			check_value("wb.base_addr", idx, LINE_BITS'(wb.base_addr),
				LINE_BITS'(vectors[idx].exp_addr));
			check_value("wb.data", idx, wb.data, vectors[idx].exp_data);
		end
		check_value("branch.valid", idx, LINE_BITS'(branch.valid),
			LINE_BITS'(vectors[idx].exp_br_valid));
		if (vectors[idx].exp_br_valid)
		begin
			check_value("branch.target_pc", idx, LINE_BITS'(branch.target_pc),
				LINE_BITS'(vectors[idx].exp_target));
		end
	endtask

	initial
	begin
		void'($urandom(RAND_SEED));
		arst_n = 1'b0;
		instr_in = '0;
		errors = 0;
		checks = 0;
		num_filled = 0;
		build_vectors();
		compute_expected();

		repeat (RESET_CYCLES) @(posedge clk);
		check_idle();
		@(negedge clk);
		arst_n = 1'b1;

		// results of entry i show up three negedges after it is driven
		for (int i = 0; i < NUM_ENTRIES + LATENCY; i++)
		begin
			@(negedge clk);
			if (i >= LATENCY)
				check_outputs(i - LATENCY);
			else
				check_idle();
			if (i < NUM_ENTRIES)
				instr_in = vectors[i].instr;
			else
				instr_in = '0;
		end
		@(negedge clk);
		check_idle();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		#(CLK_PERIOD * (NUM_ENTRIES + RESET_CYCLES + 10));
		$display("watchdog expired before the test sequence finished");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ex_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_top
#(
	parameter int HIST_DEPTH = 3
)
(
	input logic clk,
	input logic arst_n,
	input ex_pkg::ex_instr_t instr_in,
	output ex_pkg::ex_result_t wb,
	output ex_pkg::ex_branch_t branch
);
	import ex_pkg::*;

	ex_instr_t fwd;
	ex_align_t align;

	// wb loops back as history entry 0
	ex_operand_forward
	#(
		.HIST_DEPTH(HIST_DEPTH)
	)
	fwd0
	(
		.clk(clk),
		.arst_n(arst_n),
		.instr_in(instr_in),
		.wb(wb),
		.fwd_out(fwd)
	);

	ex_lane_align align0
	(
		.clk(clk),
		.arst_n(arst_n),
		.fwd_in(fwd),
		.align_out(align)
	);

	ex_result_merge merge0
	(
		.clk(clk),
		.arst_n(arst_n),
		.align_in(align),
		.wb(wb),
		.branch(branch)
	);

endmodule

`default_nettype wire

// ==== ex_result_merge.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_result_merge
(
	input logic clk,
	input logic arst_n,
	input ex_pkg::ex_align_t align_in,
	output ex_pkg::ex_result_t wb,
	output ex_pkg::ex_branch_t branch
);
	import ex_pkg::*;

	ex_result_t wb_next;
	ex_branch_t branch_next;
	logic [PC_BITS-1:0] taken_pc;

	assign taken_pc = align_in.pc + align_in.imm;

	always_comb
	begin
		wb_next.valid = 1'b0;
		wb_next.base_addr = align_in.dest_addr;
		wb_next.data = (align_in.dest_data & ~align_in.mask)
			| (align_in.rotated & align_in.mask);
		branch_next.valid = 1'b0;
		branch_next.target_pc = align_in.pc;

		case (align_in.op)
			op_insert: wb_next.valid = align_in.valid;
			op_btru:
			begin
				branch_next.valid = align_in.valid;
				if (align_in.scalar != '0)
					branch_next.target_pc = taken_pc;
			end
			op_bfal:
			begin
				branch_next.valid = align_in.valid;
				if (align_in.scalar == '0)
					branch_next.target_pc = taken_pc;
			end
			op_jmp:
			begin
				branch_next.valid = align_in.valid;
				branch_next.target_pc = PC_BITS'(align_in.scalar);
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wb <= '0;
			branch <= '0;
		end
		else
		begin
			wb <= wb_next;
			branch <= branch_next;
		end
	end

endmodule

`default_nettype wire

// ==== ex_lane_align.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_lane_align
(
	input logic clk,
	input logic arst_n,
	input ex_pkg::ex_instr_t fwd_in,
	output ex_pkg::ex_align_t align_out
);
	import ex_pkg::*;

	logic [LINE_BITS-1:0] rotated;
	logic [LINE_BITS-1:0] mask;
	logic [1:0] size_log2;
	logic [OFFSET_BITS-1:0] dst_base;
	logic [LINE_BITS-1:0] dest_field;
	ex_align_t align_next;

	lar_rotate_mask rot0
	(
		.line(fwd_in.dsrc0.data),
		.src_offset(fwd_in.dsrc0.data_offset),
		.dst_offset(fwd_in.ddest.data_offset),
		.int_size(fwd_in.ddest.int_size),
		.rotated(rotated),
		.mask(mask)
	);

	// element-aligned byte position of the destination
	assign size_log2 = fwd_in.ddest.int_size;
	assign dst_base = (fwd_in.ddest.data_offset >> size_log2) << size_log2;
	assign dest_field = (fwd_in.ddest.data & mask) >> {dst_base, 3'b000};

	always_comb
	begin
		align_next.valid = fwd_in.valid;
		align_next.op = fwd_in.op;
		align_next.pc = fwd_in.pc;
		align_next.imm = fwd_in.imm;
		align_next.dest_addr = fwd_in.ddest.base_addr;
		align_next.dest_data = fwd_in.ddest.data;
		align_next.rotated = rotated;
		align_next.mask = mask;
		// masked, so the upper bits are already zero
		align_next.scalar = dest_field[SCALAR_BITS-1:0];
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			align_out <= '0;
		else
			align_out <= align_next;
	end

endmodule

`default_nettype wire

// ==== ex_operand_forward.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_operand_forward
#(
	parameter int HIST_DEPTH = 3
)
(
	input logic clk,
	input logic arst_n,
	input ex_pkg::ex_instr_t instr_in,
	input ex_pkg::ex_result_t wb,
	output ex_pkg::ex_instr_t fwd_out
);
	import ex_pkg::*;

	// older write-backs, index 1 is one cycle back
	ex_result_t past [1:HIST_DEPTH-1];
	ex_result_t hist [HIST_DEPTH];
	ex_instr_t fwd_next;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 1; i < HIST_DEPTH; i++)
			begin
				past[i] <= '0;
			end
		end
		else
		begin
			past[1] <= wb;
			for (int i = 2; i < HIST_DEPTH; i++)
			begin
				past[i] <= past[i - 1];
			end
		end
	end

	always_comb
	begin
		hist[0] = wb;
		for (int i = 1; i < HIST_DEPTH; i++)
		begin
			hist[i] = past[i];
		end
	end

	// walk oldest to newest so the newest match is left standing
	always_comb
	begin
		fwd_next = instr_in;
		for (int i = HIST_DEPTH - 1; i >= 0; i--)
		begin
			if (hist[i].valid && (hist[i].base_addr == instr_in.ddest.base_addr))
				fwd_next.ddest.data = hist[i].data;
			if (hist[i].valid && (hist[i].base_addr == instr_in.dsrc0.base_addr))
				fwd_next.dsrc0.data = hist[i].data;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			fwd_out <= '0;
		else
			fwd_out <= fwd_next;
	end

endmodule

`default_nettype wire

// ==== lar_rotate_mask.sv ====
`default_nettype none
`timescale 1ns/1ps

module lar_rotate_mask
(
	input logic [ex_pkg::LINE_BITS-1:0] line,
	input logic [ex_pkg::OFFSET_BITS-1:0] src_offset,
	input logic [ex_pkg::OFFSET_BITS-1:0] dst_offset,
	input ex_pkg::int_size_e int_size,
	output logic [ex_pkg::LINE_BITS-1:0] rotated,
	output logic [ex_pkg::LINE_BITS-1:0] mask
);
	import ex_pkg::*;

	logic [1:0] size_log2;
	logic [OFFSET_BITS-1:0] src_idx;
	logic [OFFSET_BITS-1:0] dst_idx;
	logic [OFFSET_BITS-1:0] idx_wrap;
	logic [OFFSET_BITS-1:0] rot_elems;
	logic [OFFSET_BITS-1:0] rot_bytes;
	logic [OFFSET_BITS-1:0] dst_byte;
	logic [2*LINE_BITS-1:0] doubled;
	logic [LINE_BITS-1:0] elem_ones;

	assign size_log2 = int_size;

	// drop the byte-within-element bits
	assign src_idx = src_offset >> size_log2;
	assign dst_idx = dst_offset >> size_log2;

	// elements per line minus one, always a power of two less one
	assign idx_wrap = OFFSET_BITS'((LINE_BYTES >> size_log2) - 1);
	assign rot_elems = (dst_idx - src_idx) & idx_wrap;
	assign rot_bytes = rot_elems << size_log2;

	// rotate left, upper half of the doubled line
	assign doubled = {line, line} << {rot_bytes, 3'b000};
	assign rotated = doubled[2*LINE_BITS-1 -: LINE_BITS];

	always_comb
	begin
		case (int_size)
			sz8: elem_ones = LINE_BITS'(8'hff);
			sz16: elem_ones = LINE_BITS'(16'hffff);
			sz32: elem_ones = LINE_BITS'(32'hffff_ffff);
			sz64: elem_ones = LINE_BITS'(64'hffff_ffff_ffff_ffff);
		endcase
	end

	assign dst_byte = dst_idx << size_log2;
	assign mask = elem_ones << {dst_byte, 3'b000};

endmodule

`default_nettype wire

// ==== ex_pkg.sv ====
`default_nettype none

package ex_pkg;

	localparam int LINE_BITS = 256;
	localparam int LINE_BYTES = LINE_BITS / 8;
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);
	localparam int ADDR_BITS = 32;
	localparam int PC_BITS = 64;
	localparam int SCALAR_BITS = 64;

	// encoding doubles as log2 of the element byte count
	typedef enum logic [1:0]
	{
		sz8,
		sz16,
		sz32,
		sz64
	} int_size_e;

	typedef enum logic [1:0]
	{
		op_insert,
		op_btru,
		op_bfal,
		op_jmp
	} ex_op_e;

	typedef struct packed
	{
		logic [ADDR_BITS-1:0] base_addr;
		logic [LINE_BITS-1:0] data;
		logic [OFFSET_BITS-1:0] data_offset;
		int_size_e int_size;
	} lar_operand_t;

	typedef struct packed
	{
		logic valid;
		ex_op_e op;
		logic [PC_BITS-1:0] pc;
		logic signed [PC_BITS-1:0] imm;
		lar_operand_t ddest;
		lar_operand_t dsrc0;
	} ex_instr_t;

	// stage 2 to stage 3
	typedef struct packed
	{
		logic valid;
		ex_op_e op;
		logic [PC_BITS-1:0] pc;
		logic signed [PC_BITS-1:0] imm;
		logic [ADDR_BITS-1:0] dest_addr;
		logic [LINE_BITS-1:0] dest_data;
		logic [LINE_BITS-1:0] rotated;
		logic [LINE_BITS-1:0] mask;
		logic [SCALAR_BITS-1:0] scalar;
	} ex_align_t;

	typedef struct packed
	{
		logic valid;
		logic [ADDR_BITS-1:0] base_addr;
		logic [LINE_BITS-1:0] data;
	} ex_result_t;

	typedef struct packed
	{
		logic valid;
		logic [PC_BITS-1:0] target_pc;
	} ex_branch_t;

endpackage

`default_nettype wire
